//--- design/branch_pkg.sv
`default_nettype none

package branch_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Conditional branch kinds, encoded as the funct3 field
  typedef enum logic [2:0] {
    BT_BEQ  = 3'b000,
    BT_BNE  = 3'b001,
    BT_BLT  = 3'b100,
    BT_BGE  = 3'b101,
    BT_BLTU = 3'b110,
    BT_BGEU = 3'b111
  } branch_type_t;

  // J_NONE marks a conditional branch
  typedef enum logic [1:0] {
    J_NONE = 2'd0,
    J_JAL  = 2'd1,
    J_JALR = 2'd2
  } jump_type_t;

  // BTB geometry, index is pc[5:2] and tag is pc[31:6]
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_INDEX_W = 4;
  localparam int BTB_TAG_W   = 26;

  // 2-bit saturating counter, upper bit set means predict taken
  typedef logic [1:0] ctr_t;

  localparam ctr_t CTR_STRONG_NT = 2'd0;
  localparam ctr_t CTR_WEAK_NT   = 2'd1;
  localparam ctr_t CTR_WEAK_T    = 2'd2;
  localparam ctr_t CTR_STRONG_T  = 2'd3;

endpackage

`default_nettype wire

//--- design/branch_issue_stage.sv
`default_nettype none

module branch_issue_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     issue,
  input  logic                     hold,
  input  branch_pkg::word_t        issue_pc,
  input  branch_pkg::word_t        issue_imm,
  input  branch_pkg::word_t        issue_reg_a,
  input  branch_pkg::word_t        issue_reg_b,
  input  branch_pkg::branch_type_t issue_branch_type,
  input  branch_pkg::jump_type_t   issue_jump_type,
  input  logic                     issue_predicted,
  output logic                     enable,
  output branch_pkg::word_t        pc,
  output branch_pkg::word_t        imm,
  output branch_pkg::word_t        reg_a,
  output branch_pkg::word_t        reg_b,
  output branch_pkg::branch_type_t branch_type,
  output branch_pkg::jump_type_t   jump_type,
  output logic                     predicted
);

  logic load;

  // Commit holding the stage blocks any new issue
  assign load = issue && !hold;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      enable <= 1'b0;
    end else if (!hold) begin
      enable <= issue;
    end
  end

  // Operand register keeps its contents until the next accepted issue
  always_ff @(posedge CLK) begin
    if (load) begin
      pc          <= issue_pc;
      imm         <= issue_imm;
      reg_a       <= issue_reg_a;
      reg_b       <= issue_reg_b;
      branch_type <= issue_branch_type;
      jump_type   <= issue_jump_type;
      predicted   <= issue_predicted;
    end
  end

endmodule

`default_nettype wire

//--- design/branch_resolver.sv
`default_nettype none

module branch_resolver (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     enable,
  input  branch_pkg::word_t        pc,
  input  branch_pkg::word_t        imm,
  input  branch_pkg::word_t        reg_a,
  input  branch_pkg::word_t        reg_b,
  input  branch_pkg::branch_type_t branch_type,
  input  branch_pkg::jump_type_t   jump_type,
  input  logic                     predicted,
  output logic                     update_btb,
  output branch_pkg::word_t        update_pc,
  output branch_pkg::word_t        branch_target,
  output logic                     branch_outcome,
  output logic                     miss,
  output logic                     is_jump,
  output branch_pkg::word_t        correct_pc,
  output branch_pkg::word_t        link_data
);

  logic              cmp_eq;
  logic              cmp_lt;
  logic              cmp_ltu;
  logic              cond_taken;
  logic              updated;
  branch_pkg::word_t last_pc;
  branch_pkg::word_t seq_pc;
  branch_pkg::word_t jalr_sum;

  // Shared comparators that the inverted types reuse
  assign cmp_eq  = reg_a == reg_b;
  assign cmp_lt  = $signed(reg_a) < $signed(reg_b);
  assign cmp_ltu = reg_a < reg_b;

  always_comb begin
    case (branch_type)
      branch_pkg::BT_BEQ:  cond_taken = cmp_eq;
      branch_pkg::BT_BNE:  cond_taken = !cmp_eq;
      branch_pkg::BT_BLT:  cond_taken = cmp_lt;
      branch_pkg::BT_BGE:  cond_taken = !cmp_lt;
      branch_pkg::BT_BLTU: cond_taken = cmp_ltu;
      branch_pkg::BT_BGEU: cond_taken = !cmp_ltu;
      default:             cond_taken = 1'b0;
    endcase
  end

  // Immediate arrives already decoded and sign extended
  assign seq_pc        = pc + 32'd4;
  assign branch_target = pc + imm;
  assign jalr_sum      = reg_a + imm;

  assign is_jump        = jump_type != branch_pkg::J_NONE;
  assign branch_outcome = cond_taken;
  assign link_data      = seq_pc;
  assign update_pc      = pc;

  // Jumps always redirect and never count as mispredictions
  assign miss = !is_jump && (cond_taken != predicted);

  always_comb begin
    case (jump_type)
      branch_pkg::J_JAL:  correct_pc = branch_target;
      branch_pkg::J_JALR: correct_pc = jalr_sum & ~32'd1;
      default:            correct_pc = cond_taken ? branch_target : seq_pc;
    endcase
  end

  // Only the first cycle of a held conditional branch may train the BTB
  assign update_btb = enable && !is_jump && !(updated && last_pc == pc);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      updated <= 1'b0;
      last_pc <= '0;
    end else begin
      updated <= enable && !is_jump;
      if (enable) begin
        last_pc <= pc;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/branch_target_buffer.sv
`default_nettype none

module branch_target_buffer (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              update_btb,
  input  branch_pkg::word_t update_pc,
  input  branch_pkg::word_t branch_target,
  input  logic              branch_outcome,
  input  branch_pkg::word_t fetch_pc,
  output logic              btb_hit,
  output logic              btb_taken,
  output branch_pkg::word_t btb_target
);

  logic [branch_pkg::BTB_ENTRIES-1:0] valid;
  logic [branch_pkg::BTB_TAG_W-1:0]   tag_mem [branch_pkg::BTB_ENTRIES];
  branch_pkg::word_t                  target_mem [branch_pkg::BTB_ENTRIES];
  branch_pkg::ctr_t                   ctr_mem [branch_pkg::BTB_ENTRIES];

  logic [branch_pkg::BTB_INDEX_W-1:0] upd_idx;
  logic [branch_pkg::BTB_TAG_W-1:0]   upd_tag;
  logic [branch_pkg::BTB_INDEX_W-1:0] fetch_idx;
  logic [branch_pkg::BTB_TAG_W-1:0]   fetch_tag;
  logic                               upd_hit;
  branch_pkg::ctr_t                   ctr_cur;
  branch_pkg::ctr_t                   ctr_next;

  assign upd_idx   = update_pc[branch_pkg::BTB_INDEX_W+1:2];
  assign upd_tag   = update_pc[31:branch_pkg::BTB_INDEX_W+2];
  assign fetch_idx = fetch_pc[branch_pkg::BTB_INDEX_W+1:2];
  assign fetch_tag = fetch_pc[31:branch_pkg::BTB_INDEX_W+2];

  assign upd_hit = valid[upd_idx] && tag_mem[upd_idx] == upd_tag;
  assign ctr_cur = ctr_mem[upd_idx];

  // Saturating step toward the resolved outcome
  always_comb begin
    ctr_next = ctr_cur;
    if (branch_outcome) begin
      if (ctr_cur != branch_pkg::CTR_STRONG_T) begin
        ctr_next = ctr_cur + 2'd1;
      end
    end else if (ctr_cur != branch_pkg::CTR_STRONG_NT) begin
      ctr_next = ctr_cur - 2'd1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (update_btb) begin
      valid[upd_idx] <= 1'b1;
    end
  end

  // A tag miss evicts the old entry and starts at the weak state of the outcome
  always_ff @(posedge CLK) begin
    if (update_btb) begin
      if (upd_hit) begin
        ctr_mem[upd_idx] <= ctr_next;
      end else begin
        tag_mem[upd_idx]    <= upd_tag;
        target_mem[upd_idx] <= branch_target;
        ctr_mem[upd_idx]    <= branch_outcome ? branch_pkg::CTR_WEAK_T
                                              : branch_pkg::CTR_WEAK_NT;
      end
    end
  end

  // Fetch lookup
  assign btb_hit    = valid[fetch_idx] && tag_mem[fetch_idx] == fetch_tag;
  assign btb_taken  = btb_hit && ctr_mem[fetch_idx][1];
  assign btb_target = btb_hit ? target_mem[fetch_idx] : '0;

endmodule

`default_nettype wire

//--- design/branch_redirect.sv
`default_nettype none

module branch_redirect (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              resolved_valid,
  input  logic              miss,
  input  logic              is_jump,
  input  branch_pkg::word_t correct_pc,
  input  branch_pkg::word_t link_data,
  output logic              redirect,
  output branch_pkg::word_t redirect_pc,
  output logic              link_valid,
  output branch_pkg::word_t link_data_out,
  output logic              branch_done
);

  // Front end must refetch on a misprediction or any jump
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      redirect    <= 1'b0;
      link_valid  <= 1'b0;
      branch_done <= 1'b0;
    end else begin
      redirect    <= resolved_valid && (miss || is_jump);
      link_valid  <= resolved_valid && is_jump;
      branch_done <= resolved_valid;
    end
  end

  // Payload follows the resolver while the operation is valid
  always_ff @(posedge CLK) begin
    if (resolved_valid) begin
      redirect_pc   <= correct_pc;
      link_data_out <= link_data;
    end
  end

endmodule

`default_nettype wire

//--- design/branch_unit.sv
`default_nettype none

module branch_unit (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     issue,
  input  logic                     hold,
  input  branch_pkg::word_t        issue_pc,
  input  branch_pkg::word_t        issue_imm,
  input  branch_pkg::word_t        issue_reg_a,
  input  branch_pkg::word_t        issue_reg_b,
  input  branch_pkg::branch_type_t issue_branch_type,
  input  branch_pkg::jump_type_t   issue_jump_type,
  input  logic                     issue_predicted,
  input  branch_pkg::word_t        fetch_pc,
  output logic                     btb_hit,
  output logic                     btb_taken,
  output branch_pkg::word_t        btb_target,
  output logic                     redirect,
  output branch_pkg::word_t        redirect_pc,
  output logic                     link_valid,
  output branch_pkg::word_t        link_data,
  output logic                     branch_done
);

  // Issue stage to resolver
  logic                     enable;
  branch_pkg::word_t        pc;
  branch_pkg::word_t        imm;
  branch_pkg::word_t        reg_a;
  branch_pkg::word_t        reg_b;
  branch_pkg::branch_type_t branch_type;
  branch_pkg::jump_type_t   jump_type;
  logic                     predicted;

  // Resolver to BTB and redirect stage
  logic              update_btb;
  branch_pkg::word_t update_pc;
  branch_pkg::word_t branch_target;
  logic              branch_outcome;
  logic              miss;
  logic              is_jump;
  branch_pkg::word_t correct_pc;
  branch_pkg::word_t res_link_data;

  branch_issue_stage issue0 (
    .CLK, .nRST, .issue, .hold,
    .issue_pc, .issue_imm, .issue_reg_a, .issue_reg_b,
    .issue_branch_type, .issue_jump_type, .issue_predicted,
    .enable, .pc, .imm, .reg_a, .reg_b,
    .branch_type, .jump_type, .predicted
  );

  branch_resolver resolver0 (
    .CLK, .nRST, .enable, .pc, .imm, .reg_a, .reg_b,
    .branch_type, .jump_type, .predicted,
    .update_btb, .update_pc, .branch_target, .branch_outcome,
    .miss, .is_jump, .correct_pc,
    .link_data (res_link_data)
  );

  branch_target_buffer btb0 (
    .CLK, .nRST, .update_btb, .update_pc, .branch_target, .branch_outcome,
    .fetch_pc, .btb_hit, .btb_taken, .btb_target
  );

  branch_redirect redirect0 (
    .CLK, .nRST,
    .resolved_valid (enable),
    .miss, .is_jump, .correct_pc,
    .link_data      (res_link_data),
    .redirect, .redirect_pc, .link_valid,
    .link_data_out  (link_data),
    .branch_done
  );

endmodule

`default_nettype wire

//--- include/branch_tb_model.svh
`ifndef BRANCH_TB_MODEL_SVH
`define BRANCH_TB_MODEL_SVH

// Model copy of the BTB, same index and tag split as the table
logic [branch_pkg::BTB_ENTRIES-1:0] m_valid;
logic [branch_pkg::BTB_TAG_W-1:0]   m_tag [branch_pkg::BTB_ENTRIES];
branch_pkg::word_t                  m_target [branch_pkg::BTB_ENTRIES];
branch_pkg::ctr_t                   m_ctr [branch_pkg::BTB_ENTRIES];

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  logic fb;
  fb = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], fb};
endfunction

// Gathers nbits fresh bits, one step per bit
function automatic logic [31:0] lfsr_bits(ref logic [31:0] state, input int nbits);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < nbits; i++) begin
    state = lfsr_step(state);
    val   = {val[30:0], state[0]};
  end
  return val;
endfunction

function automatic logic model_taken(input branch_pkg::branch_type_t bt,
                                     input branch_pkg::word_t a, input branch_pkg::word_t b);
  case (bt)
    branch_pkg::BT_BEQ:  return a == b;
    branch_pkg::BT_BNE:  return a != b;
    branch_pkg::BT_BLT:  return $signed(a) < $signed(b);
    branch_pkg::BT_BGE:  return $signed(a) >= $signed(b);
    branch_pkg::BT_BLTU: return a < b;
    branch_pkg::BT_BGEU: return a >= b;
    default:             return 1'b0;
  endcase
endfunction

// Next pc after resolution, for branches and both jumps
function automatic branch_pkg::word_t model_next_pc(
    input branch_pkg::word_t pc, input branch_pkg::word_t imm, input branch_pkg::word_t a,
    input branch_pkg::word_t b, input branch_pkg::branch_type_t bt,
    input branch_pkg::jump_type_t jt);
  case (jt)
    branch_pkg::J_JAL:  return pc + imm;
    branch_pkg::J_JALR: return (a + imm) & ~32'd1;
    default:            return model_taken(bt, a, b) ? pc + imm : pc + 32'd4;
  endcase
endfunction

function automatic void model_btb_clear();
  m_valid = '0;
endfunction

function automatic void model_btb_update(input branch_pkg::word_t pc,
                                         input branch_pkg::word_t target, input logic taken);
  logic [branch_pkg::BTB_INDEX_W-1:0] idx;
  idx = pc[branch_pkg::BTB_INDEX_W+1:2];
  if (m_valid[idx] && m_tag[idx] == pc[31:branch_pkg::BTB_INDEX_W+2]) begin
    if (taken && m_ctr[idx] != branch_pkg::CTR_STRONG_T) m_ctr[idx] = m_ctr[idx] + 2'd1;
    if (!taken && m_ctr[idx] != branch_pkg::CTR_STRONG_NT) m_ctr[idx] = m_ctr[idx] - 2'd1;
  end else begin
    m_valid[idx]  = 1'b1;
    m_tag[idx]    = pc[31:branch_pkg::BTB_INDEX_W+2];
    m_target[idx] = target;
    m_ctr[idx]    = taken ? branch_pkg::CTR_WEAK_T : branch_pkg::CTR_WEAK_NT;
  end
endfunction

function automatic void model_btb_lookup(input branch_pkg::word_t pc, output logic hit,
                                         output logic taken, output branch_pkg::word_t target);
  logic [branch_pkg::BTB_INDEX_W-1:0] idx;
  idx    = pc[branch_pkg::BTB_INDEX_W+1:2];
  hit    = m_valid[idx] && m_tag[idx] == pc[31:branch_pkg::BTB_INDEX_W+2];
  taken  = hit && m_ctr[idx][1];
  target = hit ? m_target[idx] : '0;
endfunction

`endif

//--- test/branch_unit_tb.sv
`default_nettype none

module branch_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_LOOKUP = 8;
  localparam int N_BRANCH = 200;
  localparam int N_JUMP   = 100;
  localparam int N_ALIAS  = 120;
  localparam int N_HOLD   = 20;
  // Lookups take 2 cycles, plain ops 3, held ops at most 12, reset 8
  localparam int TIMEOUT_CYCLES =
    4 * (8 + 2 * N_LOOKUP + 3 * (N_BRANCH + N_JUMP + N_ALIAS) + 12 * 2 * N_HOLD);

  logic                     CLK, nRST, issue, hold, issue_predicted;
  logic                     btb_hit, btb_taken, redirect, link_valid, branch_done;
  branch_pkg::word_t        issue_pc, issue_imm, issue_reg_a, issue_reg_b, fetch_pc;
  branch_pkg::word_t        btb_target, redirect_pc, link_data;
  branch_pkg::branch_type_t issue_branch_type;
  branch_pkg::jump_type_t   issue_jump_type;
  logic [31:0]              lfsr_state = 32'd80;
  branch_pkg::word_t        alias_pc [4];
  int                       tests, checks, errors, test_checks, test_errors, cycles;

  `include "branch_tb_model.svh"

  branch_unit dut0 (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    $display("run stopped after %0d cycles without finishing", cycles);
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] rand_bits(input int n);
    return lfsr_bits(lfsr_state, n);
  endfunction

  function automatic branch_pkg::word_t rand_pc();
    logic [31:0] r;
    r = rand_bits(30);
    return {r[29:0], 2'b00};
  endfunction

  // Equal operands and sign boundaries come up often
  function automatic branch_pkg::word_t pick_operand(input branch_pkg::word_t other);
    logic [31:0] r;
    r = rand_bits(3);
    case (r[2:0])
      3'd0, 3'd1: return other;
      3'd2:       return 32'h8000_0000;
      3'd3:       return 32'h7fff_ffff;
      3'd4:       return 32'hffff_ffff;
      default:    return rand_bits(32);
    endcase
  endfunction

  function automatic branch_pkg::branch_type_t pick_branch_type();
    logic [31:0] r;
    r = rand_bits(3);
    case (r[2:0])
      3'd0, 3'd6: return branch_pkg::BT_BEQ;
      3'd1, 3'd7: return branch_pkg::BT_BNE;
      3'd2:       return branch_pkg::BT_BLT;
      3'd3:       return branch_pkg::BT_BGE;
      3'd4:       return branch_pkg::BT_BLTU;
      default:    return branch_pkg::BT_BGEU;
    endcase
  endfunction

  task automatic check_word(input string name, input branch_pkg::word_t got, exp);
    test_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    test_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_btb(input branch_pkg::word_t pc);
    logic              hit;
    logic              taken;
    branch_pkg::word_t target;
    model_btb_lookup(pc, hit, taken, target);
    test_checks++;
    if ({btb_hit, btb_taken, btb_target} !== {hit, taken, target}) begin
      test_errors++;
      $display("mismatch btb hit/taken/target at 0x%08h: got 0x%h/0x%h/0x%08h, %s",
               pc, btb_hit, btb_taken, btb_target,
               $sformatf("expected 0x%h/0x%h/0x%08h", hit, taken, target));
    end
  endtask

  task automatic finish_test(input string name);
    $display("%-14s %0d checks, %0d errors", name, test_checks, test_errors);
    tests++;
    checks += test_checks;
    errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic drive_issue(input branch_pkg::word_t pc, imm, a, b,
                             input branch_pkg::branch_type_t bt,
                             input branch_pkg::jump_type_t jt, input logic pred);
    issue             = 1'b1;
    issue_pc          = pc;
    issue_imm         = imm;
    issue_reg_a       = a;
    issue_reg_b       = b;
    issue_branch_type = bt;
    issue_jump_type   = jt;
    issue_predicted   = pred;
  endtask

  // One operation, held for some cycles if asked, with blocked issues on top
  task automatic run_op(input branch_pkg::jump_type_t jt, input branch_pkg::word_t pc,
                        input int held, input logic inject);
    branch_pkg::word_t        imm;
    branch_pkg::word_t        a;
    branch_pkg::word_t        b;
    branch_pkg::word_t        exp_pc;
    branch_pkg::branch_type_t bt;
    logic [31:0]              r;
    logic                     taken;
    int                       n;
    bt = pick_branch_type();
    a  = pick_operand(rand_bits(32));
    b  = pick_operand(a);
    r  = rand_bits(22);
    case (jt)
      branch_pkg::J_JAL:  imm = {{11{r[20]}}, r[20:1], 1'b0};
      branch_pkg::J_JALR: imm = {{20{r[11]}}, r[11:0]};
      default:            imm = {{19{r[12]}}, r[12:1], 1'b0};
    endcase
    @(negedge CLK);
    drive_issue(pc, imm, a, b, bt, jt, r[21]);
    fetch_pc = pc;
    @(negedge CLK);
    issue = 1'b0;
    hold  = held > 0;
    if (inject) begin
      drive_issue(pc ^ 32'h0000_0100, imm + 32'd8, ~a, ~b, bt, jt, !r[21]);
    end
    exp_pc = model_next_pc(pc, imm, a, b, bt, jt);
    taken  = model_taken(bt, a, b);
    if (jt == branch_pkg::J_NONE) begin
      model_btb_update(pc, pc + imm, taken);
    end
    n = (held > 0) ? held : 1;
    for (int i = 0; i < n; i++) begin
      @(negedge CLK);
      check_bit("branch_done", branch_done, 1'b1);
      check_bit("redirect", redirect, jt != branch_pkg::J_NONE || taken != r[21]);
      check_word("redirect_pc", redirect_pc, exp_pc);
      check_bit("link_valid", link_valid, jt != branch_pkg::J_NONE);
      if (jt != branch_pkg::J_NONE) begin
        check_word("link_data", link_data, pc + 32'd4);
      end
      check_btb(pc);
    end
    issue = 1'b0;
    hold  = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] t;
    nRST              = 1'b0;
    issue             = 1'b0;
    hold              = 1'b0;
    issue_pc          = '0;
    issue_imm         = '0;
    issue_reg_a       = '0;
    issue_reg_b       = '0;
    issue_branch_type = branch_pkg::BT_BEQ;
    issue_jump_type   = branch_pkg::J_NONE;
    issue_predicted   = 1'b0;
    fetch_pc          = '0;
    model_btb_clear();
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    check_bit("redirect", redirect, 1'b0);
    check_bit("link_valid", link_valid, 1'b0);
    check_bit("branch_done", branch_done, 1'b0);
    repeat (N_LOOKUP) begin
      @(negedge CLK);
      fetch_pc = rand_bits(32);
      @(negedge CLK);
      check_btb(fetch_pc);
    end
    finish_test("reset_state");

    repeat (N_BRANCH) run_op(branch_pkg::J_NONE, rand_pc(), 0, 1'b0);
    finish_test("cond_branch");

    repeat (N_JUMP) begin
      r = rand_bits(1);
      run_op(r[0] ? branch_pkg::J_JALR : branch_pkg::J_JAL, rand_pc(), 0, 1'b0);
    end
    finish_test("jumps");

    // Three tags share one index and the fourth pc sits at the next index
    r = rand_bits(4);
    for (int i = 0; i < 4; i++) begin
      t = rand_bits(26);
      alias_pc[i] = {t[25:0], r[3:0] + {3'd0, i == 3}, 2'b00};
    end
    repeat (N_ALIAS) begin
      r = rand_bits(2);
      run_op(branch_pkg::J_NONE, alias_pc[r[1:0]], 0, 1'b0);
    end
    finish_test("btb_alias");

    repeat (N_HOLD) begin
      r = rand_bits(5);
      run_op(branch_pkg::J_NONE, alias_pc[r[1:0]], 2 + int'(r[4:2]), 1'b0);
    end
    finish_test("held_branch");

    repeat (N_HOLD) begin
      r = rand_bits(5);
      run_op(branch_pkg::J_NONE, alias_pc[r[1:0]], 2 + int'(r[4:2]), 1'b1);
    end
    finish_test("held_issue");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
design/branch_pkg.sv
design/branch_issue_stage.sv
design/branch_resolver.sv
design/branch_target_buffer.sv
design/branch_redirect.sv
design/branch_unit.sv
test/branch_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -j 0 \
  --top-module branch_unit_tb -f project.f -o branch_unit_sim

out=$(./obj_dir/branch_unit_sim)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi
